// File: rtl/he_pkg.sv
`default_nettype none

package he_pkg;

   // memory side and register side words
   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;
   typedef logic [7:0]  csr_addr_t;

   // one word request to memory, held until accepted
   typedef struct packed {
      logic      write;
      bus_addr_t addr;
      bus_data_t wdata;
   } mem_req_t;

   typedef enum logic [3:0] {
      S_IDLE,
      S_LOAD_A,
      S_LOAD_B,
      S_LOAD_C,
      S_COMPUTE,
      S_DRAIN,
      S_WRITEBACK,
      S_FINISH
   } seq_state_e;

   // load phases encode the operand number 0..2
   typedef enum logic [2:0] {
      PH_LOAD_A    = 3'd0,
      PH_LOAD_B    = 3'd1,
      PH_LOAD_C    = 3'd2,
      PH_COMPUTE   = 3'd3,
      PH_WRITEBACK = 3'd4
   } buf_phase_e;

   ////////////////////////////////////////////////////////////////////////////
   // register map
   localparam csr_addr_t CTRL_OFS   = 8'h00;
   localparam csr_addr_t STATUS_OFS = 8'h04;
   localparam csr_addr_t Q_OFS      = 8'h08;
   localparam csr_addr_t R_OFS      = 8'h0C;
   localparam csr_addr_t LOGN_OFS   = 8'h10;
   localparam csr_addr_t A_PTR_OFS  = 8'h14;
   localparam csr_addr_t B_PTR_OFS  = 8'h18;
   localparam csr_addr_t C_PTR_OFS  = 8'h1C;
   localparam csr_addr_t WB_PTR_OFS = 8'h20;

endpackage

`default_nettype wire

// File: rtl/he_csr_apb.sv
`timescale 1ns/1ps
`default_nettype none

module he_csr_apb
   import he_pkg::*;
#(
   parameter int coef_width_p = 30,
   parameter int max_logn_p   = 10,
   localparam int logn_w_lp   = $clog2(max_logn_p + 1)
)
(
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  csr_addr_t               paddr_i,
   input  bus_data_t               pwdata_i,
   output bus_data_t               prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,
   input  logic                    busy_i,
   input  logic                    finish_i,
   output logic                    start_o,
   output logic [coef_width_p-1:0] q_o,
   output logic [coef_width_p:0]   r_o,
   output logic [logn_w_lp-1:0]    logn_o,
   output bus_addr_t               a_ptr_o,
   output bus_addr_t               b_ptr_o,
   output bus_addr_t               c_ptr_o,
   output bus_addr_t               wb_ptr_o,
   output logic                    irq_o
);
   logic access, wr_en, mapped, done_q;

   assign access   = psel_i && penable_i;
   assign wr_en    = access && pwrite_i;
   // no wait states
   assign pready_o = 1'b1;
   assign irq_o    = done_q;

   ////////////////////////////////////////////////////////////////////////////
   // read decode
   always_comb
   begin
      mapped   = 1'b1;
      prdata_o = '0;
      case (paddr_i)
         CTRL_OFS:   prdata_o = '0;
         STATUS_OFS: prdata_o = {30'd0, done_q, busy_i};
         Q_OFS:      prdata_o = bus_data_t'(q_o);
         R_OFS:      prdata_o = bus_data_t'(r_o);
         LOGN_OFS:   prdata_o = bus_data_t'(logn_o);
         A_PTR_OFS:  prdata_o = a_ptr_o;
         B_PTR_OFS:  prdata_o = b_ptr_o;
         C_PTR_OFS:  prdata_o = c_ptr_o;
         WB_PTR_OFS: prdata_o = wb_ptr_o;
         default:    mapped = 1'b0;
      endcase
   end

   assign pslverr_o = access && !mapped;

   ////////////////////////////////////////////////////////////////////////////
   // register writes
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         q_o      <= '0;
         r_o      <= '0;
         logn_o   <= '0;
         a_ptr_o  <= '0;
         b_ptr_o  <= '0;
         c_ptr_o  <= '0;
         wb_ptr_o <= '0;
         start_o  <= 1'b0;
         done_q   <= 1'b0;
      end
      else
      begin
         // start is dropped while a run is active
         start_o <= wr_en && paddr_i == CTRL_OFS && pwdata_i[0] && !busy_i;
         if (finish_i)
            done_q <= 1'b1;
         else if (wr_en && paddr_i == STATUS_OFS && pwdata_i[1])
            done_q <= 1'b0;
         if (wr_en)
         begin
            case (paddr_i)
               Q_OFS:      q_o <= pwdata_i[coef_width_p-1:0];
               R_OFS:      r_o <= pwdata_i[coef_width_p:0];
               LOGN_OFS:
               begin
                  // keep logn within 1..max_logn_p
                  if (pwdata_i == '0)
                     logn_o <= logn_w_lp'(1);
                  else if (pwdata_i > bus_data_t'(max_logn_p))
                     logn_o <= logn_w_lp'(max_logn_p);
                  else
                     logn_o <= pwdata_i[logn_w_lp-1:0];
               end
               A_PTR_OFS:  a_ptr_o  <= pwdata_i;
               B_PTR_OFS:  b_ptr_o  <= pwdata_i;
               C_PTR_OFS:  c_ptr_o  <= pwdata_i;
               WB_PTR_OFS: wb_ptr_o <= pwdata_i;
               default:    ;
            endcase
         end
      end
   end

   // the sequencer only goes busy from a start pulse
   start_idle_a: assert property (@(posedge clk_i) disable iff (reset_i)
      start_o |-> !busy_i)
      else $error("start pulse while the sequencer is busy");

endmodule

`default_nettype wire

// File: rtl/he_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module he_sequencer
   import he_pkg::*;
#(
   parameter int max_logn_p  = 10,
   localparam int logn_w_lp  = $clog2(max_logn_p + 1)
)
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  start_i,
   input  logic [logn_w_lp-1:0]  logn_i,
   input  bus_addr_t             a_ptr_i,
   input  bus_addr_t             b_ptr_i,
   input  bus_addr_t             c_ptr_i,
   input  bus_addr_t             wb_ptr_i,
   input  logic                  dma_done_i,
   output logic                  busy_o,
   output logic                  finish_o,
   output logic                  dma_start_o,
   output bus_addr_t             dma_base_o,
   output logic                  dma_write_o,
   output logic [max_logn_p:0]   dma_count_o,
   output buf_phase_e            phase_o,
   output logic                  issue_valid_o,
   output logic [max_logn_p-2:0] issue_index_o
);
   typedef logic [max_logn_p:0]   count_t;
   typedef logic [max_logn_p-2:0] pair_t;

   seq_state_e state_q, state_n;
   pair_t      pair_q;
   logic [2:0] drain_q;
   count_t     half_n;

   assign dma_count_o = count_t'(1) << logn_i;
   assign half_n      = dma_count_o >> 1;

   always_comb
   begin
      state_n = state_q;
      case (state_q)
         S_IDLE:      if (start_i) state_n = S_LOAD_A;
         S_LOAD_A:    if (dma_done_i) state_n = S_LOAD_B;
         S_LOAD_B:    if (dma_done_i) state_n = S_LOAD_C;
         S_LOAD_C:    if (dma_done_i) state_n = S_COMPUTE;
         S_COMPUTE:   if (pair_q == pair_t'(half_n - 1'b1)) state_n = S_DRAIN;
         // buffer read plus four pipeline stages
         S_DRAIN:     if (drain_q == 3'd4) state_n = S_WRITEBACK;
         S_WRITEBACK: if (dma_done_i) state_n = S_FINISH;
         default:     state_n = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q     <= S_IDLE;
         pair_q      <= '0;
         drain_q     <= '0;
         dma_start_o <= 1'b0;
      end
      else
      begin
         state_q     <= state_n;
         pair_q      <= (state_q == S_COMPUTE) ? pair_q + 1'b1 : '0;
         drain_q     <= (state_q == S_DRAIN) ? drain_q + 1'b1 : '0;
         // one pulse on entry to each transfer phase
         dma_start_o <= state_n != state_q &&
                        state_n inside {S_LOAD_A, S_LOAD_B, S_LOAD_C, S_WRITEBACK};
      end
   end

   always_comb
   begin
      case (state_q)
         S_LOAD_A:    dma_base_o = a_ptr_i;
         S_LOAD_B:    dma_base_o = b_ptr_i;
         S_LOAD_C:    dma_base_o = c_ptr_i;
         default:     dma_base_o = wb_ptr_i;
      endcase
      case (state_q)
         S_LOAD_A:    phase_o = PH_LOAD_A;
         S_LOAD_B:    phase_o = PH_LOAD_B;
         S_LOAD_C:    phase_o = PH_LOAD_C;
         S_WRITEBACK: phase_o = PH_WRITEBACK;
         default:     phase_o = PH_COMPUTE;
      endcase
   end

   assign dma_write_o   = state_q == S_WRITEBACK;
   assign busy_o        = state_q != S_IDLE;
   assign finish_o      = state_q == S_FINISH;
   assign issue_valid_o = state_q == S_COMPUTE;
   assign issue_index_o = pair_q;

endmodule

`default_nettype wire

// File: rtl/he_dma.sv
`timescale 1ns/1ps
`default_nettype none

module he_dma
   import he_pkg::*;
#(
   parameter int coef_width_p = 30,
   parameter int max_logn_p   = 10
)
(
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    start_i,
   input  bus_addr_t               base_i,
   input  logic                    write_i,
   input  logic [max_logn_p:0]     count_i,
   output logic                    done_o,
   output logic                    mem_req_valid_o,
   output mem_req_t                mem_req_o,
   input  logic                    mem_req_ready_i,
   input  logic                    mem_rsp_valid_i,
   input  bus_data_t               mem_rsp_rdata_i,
   output logic                    load_valid_o,
   output logic [max_logn_p-1:0]   load_index_o,
   output logic [coef_width_p-1:0] load_data_o,
   output logic [max_logn_p-1:0]   rd_index_o,
   input  logic [coef_width_p-1:0] rd_data_i
);
   typedef logic [max_logn_p-1:0] idx_t;
   typedef enum logic [1:0] {
      D_IDLE,
      D_REQ,
      D_WAIT
   } dma_state_e;

   dma_state_e state_q;
   idx_t       cnt_q, last_q;
   bus_addr_t  base_q;
   logic       write_q, rsp_last;

   assign rsp_last = state_q == D_WAIT && mem_rsp_valid_i && cnt_q == last_q;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q <= D_IDLE;
         cnt_q   <= '0;
         done_o  <= 1'b0;
      end
      else
      begin
         done_o <= rsp_last;
         case (state_q)
            D_IDLE: if (start_i) state_q <= D_REQ;
            D_REQ:  if (mem_req_ready_i) state_q <= D_WAIT;
            D_WAIT:
            begin
               if (mem_rsp_valid_i)
               begin
                  // counter returns to zero for the next transfer
                  cnt_q   <= rsp_last ? '0 : cnt_q + 1'b1;
                  state_q <= rsp_last ? D_IDLE : D_REQ;
               end
            end
            default: state_q <= D_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_q == D_IDLE && start_i)
      begin
         base_q  <= base_i;
         write_q <= write_i;
         last_q  <= idx_t'(count_i - 1'b1);
      end
   end

   // buffer read runs one element ahead so data is ready in REQ
   assign rd_index_o = (state_q == D_WAIT) ? idx_t'(cnt_q + 1'b1) : cnt_q;

   assign mem_req_valid_o = state_q == D_REQ;
   always_comb
   begin
      mem_req_o.write = write_q;
      mem_req_o.addr  = base_q + (bus_addr_t'(cnt_q) << 2);
      mem_req_o.wdata = write_q ? bus_data_t'(rd_data_i) : '0;
   end

   assign load_valid_o = state_q == D_WAIT && mem_rsp_valid_i && !write_q;
   assign load_index_o = cnt_q;
   assign load_data_o  = mem_rsp_rdata_i[coef_width_p-1:0];

   // relies on the buffer holding its read data through a stall
   req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
      else $error("memory request changed while stalled");

endmodule

`default_nettype wire

// File: rtl/he_coef_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module he_coef_buffer
   import he_pkg::*;
#(
   parameter int coef_width_p = 30,
   parameter int max_logn_p   = 10
)
(
   input  logic                    clk_i,
   input  buf_phase_e              phase_i,
   input  logic                    load_valid_i,
   input  logic [max_logn_p-1:0]   load_index_i,
   input  logic [coef_width_p-1:0] load_data_i,
   input  logic [max_logn_p-1:0]   rd_index_i,
   output logic [coef_width_p-1:0] rd_data_o,
   input  logic                    issue_valid_i,
   input  logic [max_logn_p-2:0]   issue_index_i,
   input  logic                    res_valid_i,
   input  logic [max_logn_p-2:0]   res_index_i,
   input  logic [coef_width_p-1:0] res_even_i,
   input  logic [coef_width_p-1:0] res_odd_i,
   output logic                    op_valid_o,
   output logic [max_logn_p-2:0]   op_index_o,
   output logic [coef_width_p-1:0] a_even_o,
   output logic [coef_width_p-1:0] a_odd_o,
   output logic [coef_width_p-1:0] b_even_o,
   output logic [coef_width_p-1:0] b_odd_o,
   output logic [coef_width_p-1:0] c_even_o,
   output logic [coef_width_p-1:0] c_odd_o
);
   localparam int depth_lp = 2 ** (max_logn_p - 1);

   typedef logic [coef_width_p-1:0] coef_t;
   typedef logic [max_logn_p-2:0]   word_t;

   // read data per operand (A, B, C) and parity
   coef_t rdata [3][2];
   logic  rd_par_q;

   for (genvar op = 0; op < 3; op++)
   begin : g_op
      for (genvar par = 0; par < 2; par++)
      begin : g_par
         coef_t mem [depth_lp];
         logic  we;
         word_t waddr, raddr;
         coef_t wdata;

         always_comb
         begin
            we    = load_valid_i && phase_i == buf_phase_e'(op) && load_index_i[0] == par;
            waddr = load_index_i[max_logn_p-1:1];
            wdata = load_data_i;
            // results overwrite A
            if (op == 0 && res_valid_i)
            begin
               we    = 1'b1;
               waddr = res_index_i;
               wdata = par ? res_odd_i : res_even_i;
            end
            raddr = (phase_i == PH_WRITEBACK) ? rd_index_i[max_logn_p-1:1] : issue_index_i;
         end

         always_ff @(posedge clk_i)
         begin
            if (we)
               mem[waddr] <= wdata;
            rdata[op][par] <= mem[raddr];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      rd_par_q   <= rd_index_i[0];
      op_valid_o <= issue_valid_i;
      op_index_o <= issue_index_i;
   end

   // writeback reads A
   assign rd_data_o = rd_par_q ? rdata[0][1] : rdata[0][0];

   assign a_even_o = rdata[0][0];
   assign a_odd_o  = rdata[0][1];
   assign b_even_o = rdata[1][0];
   assign b_odd_o  = rdata[1][1];
   assign c_even_o = rdata[2][0];
   assign c_odd_o  = rdata[2][1];

endmodule

`default_nettype wire

// File: rtl/he_modmul_add.sv
`timescale 1ns/1ps
`default_nettype none

module he_modmul_add
#(
   parameter int coef_width_p = 30,
   parameter int max_logn_p   = 10
)
(
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic [coef_width_p-1:0] q_i,
   input  logic [coef_width_p:0]   r_i,
   input  logic                    in_valid_i,
   input  logic [max_logn_p-2:0]   in_index_i,
   input  logic [coef_width_p-1:0] a_even_i,
   input  logic [coef_width_p-1:0] a_odd_i,
   input  logic [coef_width_p-1:0] b_even_i,
   input  logic [coef_width_p-1:0] b_odd_i,
   input  logic [coef_width_p-1:0] c_even_i,
   input  logic [coef_width_p-1:0] c_odd_i,
   output logic                    out_valid_o,
   output logic [max_logn_p-2:0]   out_index_o,
   output logic [coef_width_p-1:0] out_even_o,
   output logic [coef_width_p-1:0] out_odd_o
);
   localparam int w_lp = coef_width_p;

   typedef logic [w_lp-1:0]     coef_t;
   typedef logic [2*w_lp-1:0]   prod_t;
   typedef logic [w_lp:0]       quo_t;
   typedef logic [2*w_lp+1:0]   est_t;
   // remainder before correction is below 3q
   typedef logic [w_lp+1:0]     rem_t;
   typedef logic [max_logn_p-2:0] pair_t;

   coef_t a_in [2], b_in [2], c_in [2], res [2];
   logic  [3:0] vld_q;
   pair_t idx_q [4];

   assign a_in[0] = a_even_i;
   assign a_in[1] = a_odd_i;
   assign b_in[0] = b_even_i;
   assign b_in[1] = b_odd_i;
   assign c_in[0] = c_even_i;
   assign c_in[1] = c_odd_i;

   for (genvar l = 0; l < 2; l++)
   begin : g_lane
      prod_t s1_prod, s2_prod;
      quo_t  s2_quo;
      coef_t s1_c, s2_c, s3_c, s3_rem;
      est_t  est;
      rem_t  t0, t1, t2;
      logic  [w_lp:0] sum;

      ////////////////////////////////////////////////////////////////////////
      // Barrett estimate with k = coef width
      always_comb
      begin
         est = est_t'(s1_prod[2*w_lp-1:w_lp-1]) * est_t'(r_i);
         t0  = rem_t'(s2_prod) - rem_t'(s2_quo) * rem_t'(q_i);
         t1  = (t0 >= rem_t'(q_i)) ? t0 - rem_t'(q_i) : t0;
         t2  = (t1 >= rem_t'(q_i)) ? t1 - rem_t'(q_i) : t1;
         sum = s3_rem + s3_c;
      end

      always_ff @(posedge clk_i)
      begin
         // stage 1
         s1_prod <= prod_t'(a_in[l]) * prod_t'(b_in[l]);
         s1_c    <= c_in[l];
         // stage 2
         s2_quo  <= est[2*w_lp+1:w_lp+1];
         s2_prod <= s1_prod;
         s2_c    <= s1_c;
         // stage 3
         s3_rem  <= coef_t'(t2);
         s3_c    <= s2_c;
         // stage 4, add c and fold once
         res[l]  <= (sum >= (w_lp+1)'(q_i)) ? coef_t'(sum - q_i) : coef_t'(sum);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[2:0], in_valid_i};
      idx_q[0] <= in_index_i;
      idx_q[1] <= idx_q[0];
      idx_q[2] <= idx_q[1];
      idx_q[3] <= idx_q[2];
   end

   assign out_valid_o = vld_q[3];
   assign out_index_o = idx_q[3];
   assign out_even_o  = res[0];
   assign out_odd_o   = res[1];

endmodule

`default_nettype wire

// File: rtl/he_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module he_accel_top
   import he_pkg::*;
#(
   parameter int coef_width_p = 30,
   parameter int max_logn_p   = 10
)
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  csr_addr_t paddr_i,
   input  bus_data_t pwdata_i,
   output bus_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,
   output logic      mem_req_valid_o,
   output mem_req_t  mem_req_o,
   input  logic      mem_req_ready_i,
   input  logic      mem_rsp_valid_i,
   input  bus_data_t mem_rsp_rdata_i,
   output logic      irq_o
);
   localparam int logn_w_lp = $clog2(max_logn_p + 1);

   logic                    start, busy, finish;
   logic [coef_width_p-1:0] q;
   logic [coef_width_p:0]   r;
   logic [logn_w_lp-1:0]    logn;
   bus_addr_t               a_ptr, b_ptr, c_ptr, wb_ptr;

   logic                    dma_start, dma_write, dma_done;
   bus_addr_t               dma_base;
   logic [max_logn_p:0]     dma_count;
   buf_phase_e              phase;

   logic                    load_valid;
   logic [max_logn_p-1:0]   load_index, rd_index;
   logic [coef_width_p-1:0] load_data, rd_data;

   logic                    issue_valid, op_valid, res_valid;
   logic [max_logn_p-2:0]   issue_index, op_index, res_index;
   logic [coef_width_p-1:0] a_even, a_odd, b_even, b_odd, c_even, c_odd;
   logic [coef_width_p-1:0] res_even, res_odd;

   he_csr_apb #(.coef_width_p(coef_width_p), .max_logn_p(max_logn_p)) csr_i (
      .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o,
      .busy_i(busy), .finish_i(finish), .start_o(start),
      .q_o(q), .r_o(r), .logn_o(logn),
      .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .c_ptr_o(c_ptr), .wb_ptr_o(wb_ptr),
      .irq_o
   );

   he_sequencer #(.max_logn_p(max_logn_p)) seq_i (
      .clk_i, .reset_i, .start_i(start), .logn_i(logn),
      .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .c_ptr_i(c_ptr), .wb_ptr_i(wb_ptr),
      .dma_done_i(dma_done), .busy_o(busy), .finish_o(finish),
      .dma_start_o(dma_start), .dma_base_o(dma_base), .dma_write_o(dma_write),
      .dma_count_o(dma_count), .phase_o(phase),
      .issue_valid_o(issue_valid), .issue_index_o(issue_index)
   );

   he_dma #(.coef_width_p(coef_width_p), .max_logn_p(max_logn_p)) dma_i (
      .clk_i, .reset_i, .start_i(dma_start), .base_i(dma_base),
      .write_i(dma_write), .count_i(dma_count), .done_o(dma_done),
      .mem_req_valid_o, .mem_req_o, .mem_req_ready_i,
      .mem_rsp_valid_i, .mem_rsp_rdata_i,
      .load_valid_o(load_valid), .load_index_o(load_index), .load_data_o(load_data),
      .rd_index_o(rd_index), .rd_data_i(rd_data)
   );

   he_coef_buffer #(.coef_width_p(coef_width_p), .max_logn_p(max_logn_p)) buf_i (
      .clk_i, .phase_i(phase),
      .load_valid_i(load_valid), .load_index_i(load_index), .load_data_i(load_data),
      .rd_index_i(rd_index), .rd_data_o(rd_data),
      .issue_valid_i(issue_valid), .issue_index_i(issue_index),
      .res_valid_i(res_valid), .res_index_i(res_index),
      .res_even_i(res_even), .res_odd_i(res_odd),
      .op_valid_o(op_valid), .op_index_o(op_index),
      .a_even_o(a_even), .a_odd_o(a_odd), .b_even_o(b_even), .b_odd_o(b_odd),
      .c_even_o(c_even), .c_odd_o(c_odd)
   );

   he_modmul_add #(.coef_width_p(coef_width_p), .max_logn_p(max_logn_p)) alu_i (
      .clk_i, .reset_i, .q_i(q), .r_i(r),
      .in_valid_i(op_valid), .in_index_i(op_index),
      .a_even_i(a_even), .a_odd_i(a_odd), .b_even_i(b_even), .b_odd_i(b_odd),
      .c_even_i(c_even), .c_odd_i(c_odd),
      .out_valid_o(res_valid), .out_index_o(res_index),
      .out_even_o(res_even), .out_odd_o(res_odd)
   );

endmodule

`default_nettype wire

// File: testbench/he_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module he_mem_model
   import he_pkg::*;
#(
   parameter int addr_bits_p = 16
)
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      stall_en_i,
   input  logic      req_valid_i,
   input  mem_req_t  req_i,
   output logic      req_ready_o,
   output logic      rsp_valid_o,
   output bus_data_t rsp_rdata_o
);
   localparam int words_lp = 2 ** (addr_bits_p - 2);

   typedef logic [addr_bits_p-3:0] word_t;

   // word storage, preloaded and inspected by the testbench
   bus_data_t mem [words_lp];

   logic       pending_q;
   logic [1:0] wait_q;
   word_t      rd_word_q;

   always @(posedge clk_i)
   begin
      word_t word;
      word = req_i.addr[addr_bits_p-1:2];
      if (reset_i)
      begin
         req_ready_o <= 1'b0;
         rsp_valid_o <= 1'b0;
         rsp_rdata_o <= '0;
         pending_q   <= 1'b0;
         wait_q      <= '0;
      end
      else
      begin
         // ready drops about one cycle in three when stalls are on
         req_ready_o <= stall_en_i ? ($urandom_range(2, 0) != 0) : 1'b1;
         rsp_valid_o <= 1'b0;
         if (pending_q)
         begin
            if (wait_q == 2'd0)
            begin
               rsp_valid_o <= 1'b1;
               rsp_rdata_o <= mem[rd_word_q];
               pending_q   <= 1'b0;
            end
            else
               wait_q <= wait_q - 1'b1;
         end
         else if (req_valid_i && req_ready_o)
         begin
            if (req_i.write)
               mem[word] <= req_i.wdata;
            rd_word_q <= word;
            pending_q <= 1'b1;
            // response follows 1 to 4 cycles after acceptance
            wait_q    <= 2'($urandom_range(3, 0));
         end
      end
   end

endmodule

`default_nettype wire

// File: testbench/he_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module he_accel_tb
   import he_pkg::*;
();
   localparam int coef_width_lp = 30;
   localparam int max_logn_lp   = 10;
   localparam int addr_bits_lp  = 16;
   localparam int mem_words_lp  = 2 ** (addr_bits_lp - 2);
   localparam int seed_lp       = 34763;
   localparam int runs_lp       = 4;
   // about 40 cycles for each of three words per coefficient, per run
   localparam int timeout_lp    = runs_lp * 40 * 3 * (2 ** max_logn_lp) + 5000;
   // primes between 2^29 and 2^30
   localparam logic [31:0] q1_lp = 32'd1073741789;
   localparam logic [31:0] q2_lp = 32'd998244353;

   logic      clk, reset;
   logic      psel, penable, pwrite;
   csr_addr_t paddr;
   bus_data_t pwdata, prdata;
   logic      pready, pslverr;
   logic      mem_req_valid, mem_req_ready, mem_rsp_valid;
   mem_req_t  mem_req;
   bus_data_t mem_rsp_rdata;
   logic      irq, stall_en;

   int        errors, checks, cycle_count;
   bus_data_t image [mem_words_lp];
   bus_data_t op_a [2 ** max_logn_lp];
   bus_data_t op_b [2 ** max_logn_lp];
   bus_data_t op_c [2 ** max_logn_lp];

   he_accel_top #(.coef_width_p(coef_width_lp), .max_logn_p(max_logn_lp)) dut_i (
      .clk_i(clk), .reset_i(reset),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req),
      .mem_req_ready_i(mem_req_ready),
      .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_rdata_i(mem_rsp_rdata),
      .irq_o(irq)
   );

   he_mem_model #(.addr_bits_p(addr_bits_lp)) mem_i (
      .clk_i(clk), .reset_i(reset), .stall_en_i(stall_en),
      .req_valid_i(mem_req_valid), .req_i(mem_req), .req_ready_o(mem_req_ready),
      .rsp_valid_o(mem_rsp_valid), .rsp_rdata_o(mem_rsp_rdata)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == timeout_lp)
      begin
         $display("timeout: no finish after %0d clock cycles, the run is stopped", timeout_lp);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference and checking

   function automatic logic [31:0] mul_add_mod(input logic [31:0] a, b, c, q);
      logic [63:0] wide;
      wide = 64'(a) * 64'(b) + 64'(c);
      return 32'(wide % 64'(q));
   endfunction

   // background words depend on the whole address
   function automatic bus_data_t fill_word(input int word);
      return 32'hC0DE_0000 ^ (32'(word) * 32'h9E37_79B9);
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input int num, input string name, input int start_errors);
      $display("test %0d, %s: %0d errors", num, name, errors - start_errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // APB access, one setup and one access cycle

   task automatic apb_access(input logic write, input csr_addr_t addr,
                             input bus_data_t wdata, output bus_data_t rdata,
                             output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      // sample in the middle of the access phase
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      check_value("pready", pready, 1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input csr_addr_t addr, input bus_data_t data);
      bus_data_t rdata;
      logic      err;
      apb_access(1'b1, addr, data, rdata, err);
      check_value("pslverr on write", err, 0);
   endtask

   task automatic apb_read_check(input csr_addr_t addr, input bus_data_t exp);
      bus_data_t rdata;
      logic      err;
      apb_access(1'b0, addr, '0, rdata, err);
      check_value($sformatf("register %02h", addr), rdata, exp);
      check_value("pslverr on read", err, 0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // memory image and runs

   task automatic put_word(input bus_addr_t addr, input bus_data_t data);
      mem_i.mem[addr >> 2] = data;
      image[addr >> 2]     = data;
   endtask

   task automatic compare_memory;
      for (int i = 0; i < mem_words_lp; i++)
         check_value($sformatf("memory word %05h", i * 4), mem_i.mem[i], image[i]);
   endtask

   task automatic wait_irq;
      do
         @(negedge clk);
      while (!irq);
   endtask

   task automatic run_poly(input int logn, input logic [31:0] q,
                           input bus_addr_t a_ptr, b_ptr, c_ptr, wb_ptr,
                           input bit double_start);
      int          n;
      logic [63:0] r;
      n = 1 << logn;
      r = (64'd1 << (2 * coef_width_lp)) / 64'(q);
      for (int i = 0; i < n; i++)
      begin
         op_a[i] = $urandom % q;
         op_b[i] = $urandom % q;
         op_c[i] = $urandom % q;
         // largest residue shows up regularly
         if (i % 7 == 0)
            op_a[i] = q - 1;
         if (i % 5 == 2)
            op_b[i] = q - 1;
         if (i % 3 == 1)
            op_c[i] = q - 1;
         put_word(a_ptr + 4 * i, op_a[i]);
         put_word(b_ptr + 4 * i, op_b[i]);
         put_word(c_ptr + 4 * i, op_c[i]);
      end
      for (int i = 0; i < n; i++)
         image[(wb_ptr >> 2) + i] = mul_add_mod(op_a[i], op_b[i], op_c[i], q);
      apb_write(Q_OFS, q);
      apb_write(R_OFS, 32'(r));
      apb_write(LOGN_OFS, logn);
      apb_write(A_PTR_OFS, a_ptr);
      apb_write(B_PTR_OFS, b_ptr);
      apb_write(C_PTR_OFS, c_ptr);
      apb_write(WB_PTR_OFS, wb_ptr);
      apb_write(CTRL_OFS, 32'h1);
      if (double_start)
      begin
         apb_read_check(STATUS_OFS, 32'h1);
         apb_write(CTRL_OFS, 32'h1);
      end
      wait_irq();
      compare_memory();
      apb_read_check(STATUS_OFS, 32'h2);
   endtask

   initial
   begin
      int        test_start;
      bus_data_t rdata;
      logic      err;
      void'($urandom(seed_lp));
      clk         = 1'b0;
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      stall_en    = 1'b0;
      errors      = 0;
      checks      = 0;
      cycle_count = 0;
      for (int i = 0; i < mem_words_lp; i++)
         put_word(i * 4, fill_word(i));
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // reset state
      test_start = errors;
      @(negedge clk);
      check_value("irq_o after reset", irq, 0);
      check_value("mem_req_valid_o after reset", mem_req_valid, 0);
      for (int ofs = 0; ofs <= 32; ofs += 4)
         apb_read_check(csr_addr_t'(ofs), 32'h0);
      report_test(1, "reset state", test_start);

      // register read-back, logn clamp, unmapped offsets
      test_start = errors;
      apb_write(Q_OFS, 32'hFFFF_FFFF);
      apb_read_check(Q_OFS, 32'h3FFF_FFFF);
      apb_write(R_OFS, 32'hFFFF_FFFF);
      apb_read_check(R_OFS, 32'h7FFF_FFFF);
      apb_write(LOGN_OFS, 7);
      apb_read_check(LOGN_OFS, 7);
      apb_write(LOGN_OFS, 25);
      apb_read_check(LOGN_OFS, max_logn_lp);
      apb_write(LOGN_OFS, 0);
      apb_read_check(LOGN_OFS, 1);
      apb_write(A_PTR_OFS, 32'h1234_5678);
      apb_read_check(A_PTR_OFS, 32'h1234_5678);
      apb_write(B_PTR_OFS, 32'h8765_4320);
      apb_read_check(B_PTR_OFS, 32'h8765_4320);
      apb_write(C_PTR_OFS, 32'hDEAD_BEE0);
      apb_read_check(C_PTR_OFS, 32'hDEAD_BEE0);
      apb_write(WB_PTR_OFS, 32'hFFFF_FFFC);
      apb_read_check(WB_PTR_OFS, 32'hFFFF_FFFC);
      apb_write(CTRL_OFS, 32'hFFFF_FFFE);
      apb_read_check(CTRL_OFS, 32'h0);
      apb_access(1'b0, 8'h24, '0, rdata, err);
      check_value("pslverr for read of 24", err, 1);
      apb_access(1'b1, 8'h40, 32'hFFFF_FFFF, rdata, err);
      check_value("pslverr for write of 40", err, 1);
      apb_read_check(STATUS_OFS, 32'h0);
      report_test(2, "register access", test_start);

      // short run without stalls
      test_start = errors;
      run_poly(4, q1_lp, 32'h1000, 32'h2000, 32'h3000, 32'h4000, 1'b0);
      apb_write(STATUS_OFS, 32'h2);
      @(negedge clk);
      check_value("irq_o after clear", irq, 0);
      report_test(3, "run at logn 4", test_start);

      // full length run with memory stalls
      test_start = errors;
      stall_en <= 1'b1;
      run_poly(max_logn_lp, q2_lp, 32'h8000, 32'h9000, 32'hA000, 32'hB000, 1'b0);
      apb_write(STATUS_OFS, 32'h2);
      report_test(4, "run at logn 10 with stalls", test_start);

      // start while busy, done clear, second run on new pointers
      test_start = errors;
      run_poly(5, q1_lp, 32'hC000, 32'hC400, 32'hC800, 32'hCC00, 1'b1);
      check_value("irq_o before clear", irq, 1);
      apb_write(STATUS_OFS, 32'h2);
      @(negedge clk);
      check_value("irq_o after clear", irq, 0);
      repeat (200) @(posedge clk);
      @(negedge clk);
      check_value("irq_o with no second run", irq, 0);
      apb_read_check(STATUS_OFS, 32'h0);
      run_poly(6, q2_lp, 32'hD000, 32'hD400, 32'hD800, 32'hDC00, 1'b0);
      apb_write(STATUS_OFS, 32'h2);
      report_test(5, "status handling", test_start);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
rtl/he_pkg.sv
rtl/he_csr_apb.sv
rtl/he_sequencer.sv
rtl/he_dma.sv
rtl/he_coef_buffer.sv
rtl/he_modmul_add.sv
rtl/he_accel_top.sv
testbench/he_mem_model.sv
testbench/he_accel_tb.sv
